// ==== hw/uarch_pkg.sv ====
package uarch_pkg;

    // ------------------------------
    // Datapath and queue sizing
    // ------------------------------
    localparam int XLEN            = 32;
    localparam int TAG_WIDTH       = 4;
    localparam int ROB_DEPTH       = 1 << TAG_WIDTH;
    // Bus ports and max retirements per cycle
    localparam int PIPE_WIDTH      = 2;
    // Two ALUs, MDU, memory unit
    localparam int NUM_SOURCES     = 4;
    localparam int SRC_IDX_WIDTH   = $clog2(NUM_SOURCES);

    // Exception record layout inside a result word
    localparam int EXC_CAUSE_WIDTH = 5;
    localparam int EXC_ADDR_WIDTH  = XLEN - EXC_CAUSE_WIDTH;

    // Cause in the top bits, faulting address fragment below
    typedef struct packed {
        logic [EXC_CAUSE_WIDTH-1:0] cause;
        logic [EXC_ADDR_WIDTH-1:0]  addr;
    } wb_exc_rec_t;

    // One result word, read through the view picked by the exception flag
    typedef union packed {
        logic [XLEN-1:0] data;
        wb_exc_rec_t     exc;
    } wb_payload_u;

endpackage

// ==== hw/fu_result_buffer.sv ====
`timescale 1ns/1ps

module fu_result_buffer (
    input  logic                            clk,
    input  logic                            rst_n,
    // Result strobe from the functional unit
    input  logic                            fu_valid,
    input  logic [uarch_pkg::TAG_WIDTH-1:0] fu_tag,
    input  logic                            fu_exc,
    input  uarch_pkg::wb_payload_u          fu_payload,
    // Grant from the bus arbiter
    input  logic                            gnt,
    // Back-pressure level to the functional unit
    output logic                            fu_ready,
    // Held result toward the arbiter
    output logic                            buf_valid,
    output logic [uarch_pkg::TAG_WIDTH-1:0] buf_tag,
    output logic                            buf_exc,
    output uarch_pkg::wb_payload_u          buf_payload
);

    logic load;

    // Free when empty or when the held result leaves this cycle
    assign fu_ready = !buf_valid || gnt;

    // Source only strobes while ready, qualify anyway
    assign load = fu_valid && fu_ready;

    // ------------------------------
    // Occupancy
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (load) begin
            // New result replaces a granted one with no bubble
            buf_valid <= 1'b1;
        end else if (gnt) begin
            buf_valid <= 1'b0;
        end
    end

    // ------------------------------
    // Result fields
    // ------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            buf_tag     <= fu_tag;
            buf_exc     <= fu_exc;
            buf_payload <= fu_payload;
        end
    end

endmodule

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
    // Head of the reorder buffer, reference point for age
    input  logic [uarch_pkg::TAG_WIDTH-1:0] rob_head,
    // Buffered results, one per source
    input  logic                            buf_valid   [uarch_pkg::NUM_SOURCES],
    input  logic [uarch_pkg::TAG_WIDTH-1:0] buf_tag     [uarch_pkg::NUM_SOURCES],
    input  logic                            buf_exc     [uarch_pkg::NUM_SOURCES],
    input  uarch_pkg::wb_payload_u          buf_payload [uarch_pkg::NUM_SOURCES],
    output logic                            buf_gnt     [uarch_pkg::NUM_SOURCES],
    // Common data bus ports, port 0 is the oldest
    output logic                            cdb_valid   [uarch_pkg::PIPE_WIDTH],
    output logic [uarch_pkg::TAG_WIDTH-1:0] cdb_tag     [uarch_pkg::PIPE_WIDTH],
    output logic                            cdb_exc     [uarch_pkg::PIPE_WIDTH],
    output uarch_pkg::wb_payload_u          cdb_payload [uarch_pkg::PIPE_WIDTH]
);

    import uarch_pkg::*;

    logic [TAG_WIDTH-1:0]     age [NUM_SOURCES];
    logic [NUM_SOURCES-1:0]   used_mask;
    logic                     sel_found [PIPE_WIDTH];
    logic [SRC_IDX_WIDTH-1:0] sel_idx   [PIPE_WIDTH];

    // Distance from head, wraps modulo the buffer size
    always_comb begin
        for (int i = 0; i < NUM_SOURCES; i++) begin
            age[i] = buf_tag[i] - rob_head;
        end
    end

    // ------------------------------
    // Oldest-first selection
    // ------------------------------
    always_comb begin : select_proc
        logic [TAG_WIDTH-1:0] best_age;

        used_mask = '0;
        for (int p = 0; p < PIPE_WIDTH; p++) begin
            sel_found[p] = 1'b0;
            sel_idx[p]   = '0;
            best_age     = '1;
            // Scan sources not yet taken by an earlier port
            for (int i = 0; i < NUM_SOURCES; i++) begin
                if (buf_valid[i] && !used_mask[i] &&
                    (!sel_found[p] || age[i] < best_age)) begin
                    sel_found[p] = 1'b1;
                    sel_idx[p]   = SRC_IDX_WIDTH'(i);
                    best_age     = age[i];
                end
            end
            // Mask the winner before the next port looks
            if (sel_found[p]) begin
                used_mask[sel_idx[p]] = 1'b1;
            end
        end
    end

    // Grant exactly the selected sources
    always_comb begin
        for (int i = 0; i < NUM_SOURCES; i++) begin
            buf_gnt[i] = used_mask[i];
        end
    end

    // ------------------------------
    // Route winners to bus ports
    // ------------------------------
    always_comb begin
        for (int p = 0; p < PIPE_WIDTH; p++) begin
            if (sel_found[p]) begin
                cdb_valid[p]   = 1'b1;
                cdb_tag[p]     = buf_tag[sel_idx[p]];
                cdb_exc[p]     = buf_exc[sel_idx[p]];
                cdb_payload[p] = buf_payload[sel_idx[p]];
            end else begin
                // Idle port drives all zero
                cdb_valid[p]   = 1'b0;
                cdb_tag[p]     = '0;
                cdb_exc[p]     = 1'b0;
                cdb_payload[p] = '0;
            end
        end
    end

endmodule

// ==== hw/rob_tracker.sv ====
`timescale 1ns/1ps

module rob_tracker (
    input  logic                            clk,
    input  logic                            rst_n,
    // Tag allocation in program order
    input  logic                            alloc_valid,
    output logic                            alloc_ready,
    output logic [uarch_pkg::TAG_WIDTH-1:0] alloc_tag,
    // Oldest in-flight tag, used by the arbiter
    output logic [uarch_pkg::TAG_WIDTH-1:0] rob_head,
    // Completions from the common data bus
    input  logic                            cdb_valid      [uarch_pkg::PIPE_WIDTH],
    input  logic [uarch_pkg::TAG_WIDTH-1:0] cdb_tag        [uarch_pkg::PIPE_WIDTH],
    input  logic                            cdb_exc        [uarch_pkg::PIPE_WIDTH],
    input  uarch_pkg::wb_payload_u          cdb_payload    [uarch_pkg::PIPE_WIDTH],
    // In-order retirement
    output logic                            commit_valid   [uarch_pkg::PIPE_WIDTH],
    output logic [uarch_pkg::TAG_WIDTH-1:0] commit_tag     [uarch_pkg::PIPE_WIDTH],
    output logic                            commit_exc     [uarch_pkg::PIPE_WIDTH],
    output uarch_pkg::wb_payload_u          commit_payload [uarch_pkg::PIPE_WIDTH]
);

    import uarch_pkg::*;

    // Pointers and occupancy
    logic [TAG_WIDTH-1:0] head_ptr;
    logic [TAG_WIDTH-1:0] tail_ptr;
    // One extra bit so a full buffer reads as ROB_DEPTH
    logic [TAG_WIDTH:0]   rob_count;

    // Per-entry state
    logic [ROB_DEPTH-1:0] done_q;
    logic                 exc_q     [ROB_DEPTH];
    wb_payload_u          payload_q [ROB_DEPTH];

    logic                 alloc_fire;
    logic [TAG_WIDTH:0]   retire_cnt;

    // ------------------------------
    // Allocation side
    // ------------------------------
    assign alloc_ready = (rob_count != (TAG_WIDTH+1)'(ROB_DEPTH));
    assign alloc_tag   = tail_ptr;
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign rob_head    = head_ptr;

    // ------------------------------
    // Retirement, combinational from state
    // ------------------------------
    always_comb begin : retire_proc
        logic chain;

        chain      = 1'b1;
        retire_cnt = '0;
        for (int p = 0; p < PIPE_WIDTH; p++) begin
            commit_tag[p] = head_ptr + TAG_WIDTH'(p);
            // A port retires only behind every older port
            chain = chain && (rob_count > (TAG_WIDTH+1)'(p)) && done_q[commit_tag[p]];
            commit_valid[p]   = chain;
            commit_exc[p]     = exc_q[commit_tag[p]];
            commit_payload[p] = payload_q[commit_tag[p]];
            if (chain) begin
                retire_cnt = retire_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // Pointer and count update
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            rob_count <= '0;
        end else begin
            head_ptr <= head_ptr + retire_cnt[TAG_WIDTH-1:0];
            if (alloc_fire) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            // Retire and allocate in one cycle net out here
            rob_count <= rob_count + (TAG_WIDTH+1)'(alloc_fire) - retire_cnt;
        end
    end

    // Done bits, set by the bus and cleared when an entry is handed out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            for (int p = 0; p < PIPE_WIDTH; p++) begin
                if (cdb_valid[p]) begin
                    done_q[cdb_tag[p]] <= 1'b1;
                end
            end
            // Fresh entry starts not done
            if (alloc_fire) begin
                done_q[tail_ptr] <= 1'b0;
            end
        end
    end

    // Completion payload capture
    always_ff @(posedge clk) begin
        for (int p = 0; p < PIPE_WIDTH; p++) begin
            if (cdb_valid[p]) begin
                exc_q[cdb_tag[p]]     <= cdb_exc[p];
                payload_q[cdb_tag[p]] <= cdb_payload[p];
            end
        end
    end

endmodule

// ==== hw/writeback_top.sv ====
`timescale 1ns/1ps

module writeback_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // Functional-unit result sources
    input  logic                            fu_valid       [uarch_pkg::NUM_SOURCES],
    input  logic [uarch_pkg::TAG_WIDTH-1:0] fu_tag         [uarch_pkg::NUM_SOURCES],
    input  logic                            fu_exc         [uarch_pkg::NUM_SOURCES],
    input  uarch_pkg::wb_payload_u          fu_payload     [uarch_pkg::NUM_SOURCES],
    output logic                            fu_ready       [uarch_pkg::NUM_SOURCES],
    // Tag allocation
    input  logic                            alloc_valid,
    output logic                            alloc_ready,
    output logic [uarch_pkg::TAG_WIDTH-1:0] alloc_tag,
    // Common data bus
    output logic                            cdb_valid      [uarch_pkg::PIPE_WIDTH],
    output logic [uarch_pkg::TAG_WIDTH-1:0] cdb_tag        [uarch_pkg::PIPE_WIDTH],
    output logic                            cdb_exc        [uarch_pkg::PIPE_WIDTH],
    output uarch_pkg::wb_payload_u          cdb_payload    [uarch_pkg::PIPE_WIDTH],
    // Commit
    output logic                            commit_valid   [uarch_pkg::PIPE_WIDTH],
    output logic [uarch_pkg::TAG_WIDTH-1:0] commit_tag     [uarch_pkg::PIPE_WIDTH],
    output logic                            commit_exc     [uarch_pkg::PIPE_WIDTH],
    output uarch_pkg::wb_payload_u          commit_payload [uarch_pkg::PIPE_WIDTH]
);

    import uarch_pkg::*;

    // Buffer to arbiter wiring
    logic                 buf_valid   [NUM_SOURCES];
    logic [TAG_WIDTH-1:0] buf_tag     [NUM_SOURCES];
    logic                 buf_exc     [NUM_SOURCES];
    wb_payload_u          buf_payload [NUM_SOURCES];
    logic                 buf_gnt     [NUM_SOURCES];

    logic [TAG_WIDTH-1:0] rob_head;

    // ------------------------------
    // One holding buffer per source
    // ------------------------------
    for (genvar i = 0; i < NUM_SOURCES; i++) begin : gen_buf
        fu_result_buffer fu_result_buffer_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .fu_valid    (fu_valid[i]),
            .fu_tag      (fu_tag[i]),
            .fu_exc      (fu_exc[i]),
            .fu_payload  (fu_payload[i]),
            .gnt         (buf_gnt[i]),
            .fu_ready    (fu_ready[i]),
            .buf_valid   (buf_valid[i]),
            .buf_tag     (buf_tag[i]),
            .buf_exc     (buf_exc[i]),
            .buf_payload (buf_payload[i])
        );
    end

    // Oldest-first bus selection
    cdb_arbiter cdb_arbiter_inst (
        .rob_head    (rob_head),
        .buf_valid   (buf_valid),
        .buf_tag     (buf_tag),
        .buf_exc     (buf_exc),
        .buf_payload (buf_payload),
        .buf_gnt     (buf_gnt),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_exc     (cdb_exc),
        .cdb_payload (cdb_payload)
    );

    // Completion tracking and in-order retirement
    rob_tracker rob_tracker_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc_valid    (alloc_valid),
        .alloc_ready    (alloc_ready),
        .alloc_tag      (alloc_tag),
        .rob_head       (rob_head),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_exc        (cdb_exc),
        .cdb_payload    (cdb_payload),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_exc     (commit_exc),
        .commit_payload (commit_payload)
    );

endmodule

// ==== bench/writeback_sva.sv ====
`timescale 1ns/1ps

module writeback_sva (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            cdb_valid    [uarch_pkg::PIPE_WIDTH],
    input logic [uarch_pkg::TAG_WIDTH-1:0] cdb_tag      [uarch_pkg::PIPE_WIDTH],
    input logic                            commit_valid [uarch_pkg::PIPE_WIDTH],
    input logic                            alloc_ready,
    input logic [uarch_pkg::TAG_WIDTH-1:0] alloc_tag,
    input logic [uarch_pkg::TAG_WIDTH:0]   rob_count
);

    import uarch_pkg::*;

    // Two bus ports never broadcast one tag
    bus_tag_unique: assert property (@(posedge clk) disable iff (!rst_n)
        (cdb_valid[0] && cdb_valid[1]) |-> (cdb_tag[0] != cdb_tag[1]))
        else $error("bus ports 0 and 1 carry the same tag");

    // Bus fills from port 0 upward
    bus_port_order: assert property (@(posedge clk) disable iff (!rst_n)
        cdb_valid[1] |-> cdb_valid[0])
        else $error("bus port 1 valid while port 0 idle");

    // Second retirement only behind the first
    commit_port_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid[1] |-> commit_valid[0])
        else $error("commit port 1 valid while port 0 idle");

    // No allocation into a full ROB, so the tail stays put
    full_blocks_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        (rob_count == (TAG_WIDTH+1)'(ROB_DEPTH)) |-> !alloc_ready ##1 $stable(alloc_tag))
        else $error("allocation taken with every entry in flight");

endmodule

// Bus ports are observed at the tracker inputs, where a clock is available
bind rob_tracker writeback_sva writeback_sva_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .commit_valid (commit_valid),
    .alloc_ready  (alloc_ready),
    .alloc_tag    (alloc_tag),
    .rob_count    (rob_count)
);

// ==== bench/writeback_tb.sv ====
`timescale 1ns/1ps

module writeback_tb;

    import uarch_pkg::*;

    // ------------------------------
    // Stimulus table
    // ------------------------------
    localparam int NUM_ROWS   = 24;
    localparam int MAX_CYCLES = NUM_ROWS * 20 + 100;

    // Launch delay counts from allocation, jit adds 0 to 3 random cycles
    typedef struct packed {
        logic [SRC_IDX_WIDTH-1:0]   src;
        logic [5:0]                 delay;
        logic                       jit;
        logic                       exc;
        logic [EXC_CAUSE_WIDTH-1:0] cause;
        logic [EXC_ADDR_WIDTH-1:0]  addr;
    } row_t;

    // Rows 0 to 15 fill the ROB behind a late head
    // Rows 16 to 23 are two four-wide bursts
    localparam row_t ROWS [NUM_ROWS] = '{
        '{2'd0, 6'd40, 1'b0, 1'b0, 5'd0,  27'h0},
        '{2'd1, 6'd6,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd2, 6'd1,  1'b1, 1'b1, 5'd13, 27'h0001f40},
        '{2'd3, 6'd3,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd1, 6'd0,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd2, 6'd8,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd3, 6'd2,  1'b1, 1'b1, 5'd5,  27'h2a0c004},
        '{2'd1, 6'd4,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd2, 6'd0,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd3, 6'd9,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd1, 6'd1,  1'b1, 1'b1, 5'd2,  27'h7ffffff},
        '{2'd2, 6'd5,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd3, 6'd0,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd1, 6'd7,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd2, 6'd2,  1'b1, 1'b0, 5'd0,  27'h0},
        '{2'd3, 6'd1,  1'b1, 1'b1, 5'd31, 27'h0000004},
        '{2'd0, 6'd6,  1'b0, 1'b0, 5'd0,  27'h0},
        '{2'd1, 6'd4,  1'b0, 1'b1, 5'd4,  27'h0100abc},
        '{2'd2, 6'd2,  1'b0, 1'b0, 5'd0,  27'h0},
        '{2'd3, 6'd0,  1'b0, 1'b0, 5'd0,  27'h0},
        '{2'd3, 6'd6,  1'b0, 1'b0, 5'd0,  27'h0},
        '{2'd2, 6'd4,  1'b0, 1'b0, 5'd0,  27'h0},
        '{2'd1, 6'd2,  1'b0, 1'b1, 5'd15, 27'h3c00010},
        '{2'd0, 6'd0,  1'b0, 1'b0, 5'd0,  27'h0}
    };

    logic                 clk;
    logic                 rst_n;
    logic                 fu_valid       [NUM_SOURCES];
    logic [TAG_WIDTH-1:0] fu_tag         [NUM_SOURCES];
    logic                 fu_exc         [NUM_SOURCES];
    wb_payload_u          fu_payload     [NUM_SOURCES];
    logic                 fu_ready       [NUM_SOURCES];
    logic                 alloc_valid;
    logic                 alloc_ready;
    logic [TAG_WIDTH-1:0] alloc_tag;
    logic                 cdb_valid      [PIPE_WIDTH];
    logic [TAG_WIDTH-1:0] cdb_tag        [PIPE_WIDTH];
    logic                 cdb_exc        [PIPE_WIDTH];
    wb_payload_u          cdb_payload    [PIPE_WIDTH];
    logic                 commit_valid   [PIPE_WIDTH];
    logic [TAG_WIDTH-1:0] commit_tag     [PIPE_WIDTH];
    logic                 commit_exc     [PIPE_WIDTH];
    wb_payload_u          commit_payload [PIPE_WIDTH];

    // Per-row launch data
    logic [TAG_WIDTH-1:0] row_tag  [NUM_ROWS];
    wb_payload_u          row_pay  [NUM_ROWS];
    int                   row_jit  [NUM_ROWS];
    bit                   src_busy [NUM_SOURCES];
    integer               seed = 32'h63af6afd;

    // Reference model of the ROB, indexed by tag
    logic [TAG_WIDTH-1:0] tag_q [$];
    int                   exp_row [ROB_DEPTH];
    bit                   waiting [ROB_DEPTH];
    bit                   on_bus  [ROB_DEPTH];
    int                   bus_cnt [ROB_DEPTH];
    // Result each source buffer holds, for the ready level
    bit                   src_held [NUM_SOURCES];
    logic [TAG_WIDTH-1:0] src_tag  [NUM_SOURCES];
    logic [TAG_WIDTH-1:0] model_head = '0;
    logic [TAG_WIDTH-1:0] model_tail = '0;
    int                   inflight   = 0;
    int                   n_retired  = 0;
    int                   n_bus      = 0;
    int                   errors     = 0;
    int                   cycle_cnt  = 0;
    bit                   run_checks = 1'b0;
    bit                   saw_full   = 1'b0;
    bit                   saw_backpressure = 1'b0;

    writeback_top writeback_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .fu_valid       (fu_valid),
        .fu_tag         (fu_tag),
        .fu_exc         (fu_exc),
        .fu_payload     (fu_payload),
        .fu_ready       (fu_ready),
        .alloc_valid    (alloc_valid),
        .alloc_ready    (alloc_ready),
        .alloc_tag      (alloc_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_exc        (cdb_exc),
        .cdb_payload    (cdb_payload),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_exc     (commit_exc),
        .commit_payload (commit_payload)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp_val,
                                   input logic [XLEN-1:0] act_val);
        errors++;
        $display("FAILED %s expected 0x%0h actual 0x%0h at %0t", name, exp_val, act_val, $time);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic finish_run();
        $display("Commits: %0d, bus results: %0d, errors: %0d", n_retired, n_bus, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // ------------------------------
    // Driving
    // ------------------------------
    task automatic alloc_row(input int r);
        do @(negedge clk); while (!alloc_ready);
        // Tail holds until this allocation lands
        row_tag[r] = alloc_tag;
        @(posedge clk);
        alloc_valid <= 1'b1;
        exp_row[row_tag[r]] = r;
        tag_q.push_back(row_tag[r]);
        @(posedge clk);
        alloc_valid <= 1'b0;
    endtask

    task automatic launch_row(input int r);
        int s;

        s = ROWS[r].src;
        repeat (ROWS[r].delay + row_jit[r]) @(posedge clk);
        // One row at a time per source
        while (src_busy[s]) @(posedge clk);
        src_busy[s] = 1'b1;
        do @(negedge clk); while (!fu_ready[s]);
        @(posedge clk);
        fu_valid[s]   <= 1'b1;
        fu_tag[s]     <= row_tag[r];
        fu_exc[s]     <= ROWS[r].exc;
        fu_payload[s] <= row_pay[r];
        @(posedge clk);
        fu_valid[s] <= 1'b0;
        src_busy[s]  = 1'b0;
    endtask

    task automatic check_reset_state();
        for (int s = 0; s < NUM_SOURCES; s++) begin
            assert (fu_ready[s]) else report_mismatch("fu_ready", 1, fu_ready[s]);
        end
        for (int p = 0; p < PIPE_WIDTH; p++) begin
            assert (!cdb_valid[p]) else report_mismatch("cdb_valid", 0, cdb_valid[p]);
            assert (!commit_valid[p]) else report_mismatch("commit_valid", 0, commit_valid[p]);
        end
        assert (alloc_ready) else report_mismatch("alloc_ready", 1, alloc_ready);
        assert (alloc_tag == '0) else report_mismatch("alloc_tag", 0, alloc_tag);
    endtask

    // ------------------------------
    // Per-cycle model check
    // ------------------------------
    task automatic check_cycle();
        logic [TAG_WIDTH-1:0] exp_bus [PIPE_WIDTH];
        logic [TAG_WIDTH-1:0] t;
        logic                 chain;
        int                   k;
        int                   n_ret;
        int                   r;

        assert (alloc_ready == (inflight < ROB_DEPTH))
            else report_mismatch("alloc_ready", inflight < ROB_DEPTH, alloc_ready);
        assert (alloc_tag == model_tail) else report_mismatch("alloc_tag", model_tail, alloc_tag);
        if (!alloc_ready) begin
            saw_full = 1'b1;
        end

        // Retirement walks the model queue from its head
        chain = 1'b1;
        n_ret = 0;
        for (int p = 0; p < PIPE_WIDTH; p++) begin
            chain = chain && (tag_q.size() > p) && on_bus[tag_q[p]];
            assert (commit_valid[p] == chain)
                else report_mismatch("commit_valid", chain, commit_valid[p]);
            if (chain) begin
                t = tag_q[p];
                r = exp_row[t];
                assert (commit_tag[p] == t) else report_mismatch("commit_tag", t, commit_tag[p]);
                assert (commit_exc[p] == ROWS[r].exc)
                    else report_mismatch("commit_exc", ROWS[r].exc, commit_exc[p]);
                if (ROWS[r].exc) begin
                    // Exception view of the retired word
                    assert (commit_payload[p].exc.cause == ROWS[r].cause)
                        else report_mismatch("commit_payload.exc.cause", ROWS[r].cause,
                                             commit_payload[p].exc.cause);
                    assert (commit_payload[p].exc.addr == ROWS[r].addr)
                        else report_mismatch("commit_payload.exc.addr", ROWS[r].addr,
                                             commit_payload[p].exc.addr);
                end else begin
                    assert (commit_payload[p].data == row_pay[r].data)
                        else report_mismatch("commit_payload", row_pay[r].data,
                                             commit_payload[p].data);
                end
                assert (bus_cnt[t] == 1)
                    else report_error($sformatf("tag 0x%0h went out on the bus %0d times",
                                                t, bus_cnt[t]));
                n_ret++;
            end
        end

        // Waiting results in age order from the model head
        k = 0;
        for (int a = 0; a < ROB_DEPTH; a++) begin
            t = model_head + TAG_WIDTH'(a);
            if (waiting[t]) begin
                if (k < PIPE_WIDTH) begin
                    exp_bus[k] = t;
                end
                k++;
            end
        end
        if (k > PIPE_WIDTH) begin
            saw_backpressure = 1'b1;
        end
        for (int p = 0; p < PIPE_WIDTH; p++) begin
            assert (cdb_valid[p] == (k > p))
                else report_mismatch("cdb_valid", k > p, cdb_valid[p]);
            if (cdb_valid[p]) begin
                bus_cnt[cdb_tag[p]]++;
                n_bus++;
            end
            if (k > p) begin
                r = exp_row[exp_bus[p]];
                assert (cdb_tag[p] == exp_bus[p])
                    else report_mismatch("cdb_tag", exp_bus[p], cdb_tag[p]);
                assert (cdb_exc[p] == ROWS[r].exc)
                    else report_mismatch("cdb_exc", ROWS[r].exc, cdb_exc[p]);
                assert (cdb_payload[p] == row_pay[r])
                    else report_mismatch("cdb_payload", row_pay[r].data, cdb_payload[p].data);
                on_bus[exp_bus[p]]  = 1'b1;
                waiting[exp_bus[p]] = 1'b0;
            end
        end

        // Model state for the next cycle
        repeat (n_ret) begin
            t = tag_q.pop_front();
            on_bus[t]  = 1'b0;
            bus_cnt[t] = 0;
        end
        model_head = model_head + TAG_WIDTH'(n_ret);
        n_retired  = n_retired + n_ret;
        inflight   = inflight - n_ret;
        if (alloc_valid && alloc_ready) begin
            inflight++;
            model_tail++;
        end
        for (int s = 0; s < NUM_SOURCES; s++) begin
            // A buffer frees up in the cycle its result goes out on the bus
            if (src_held[s] && !waiting[src_tag[s]]) begin
                src_held[s] = 1'b0;
            end
            assert (fu_ready[s] == !src_held[s])
                else report_mismatch($sformatf("fu_ready[%0d]", s), !src_held[s], fu_ready[s]);
            // Launched now, buffered next cycle
            if (fu_valid[s]) begin
                assert (fu_ready[s])
                    else report_error($sformatf("source %0d strobed while busy", s));
                waiting[fu_tag[s]] = 1'b1;
                src_held[s] = 1'b1;
                src_tag[s]  = fu_tag[s];
            end
        end
    endtask

    always @(negedge clk) begin
        if (run_checks) begin
            check_cycle();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_error("timeout with results still in flight");
            finish_run();
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n       = 1'b0;
        alloc_valid = 1'b0;
        for (int s = 0; s < NUM_SOURCES; s++) begin
            fu_valid[s]   = 1'b0;
            fu_tag[s]     = '0;
            fu_exc[s]     = 1'b0;
            fu_payload[s] = '0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (ROWS[r].exc) begin
                row_pay[r].exc.cause = ROWS[r].cause;
                row_pay[r].exc.addr  = ROWS[r].addr;
            end else begin
                row_pay[r].data = $random(seed);
            end
            row_jit[r] = ROWS[r].jit ? ($random(seed) & 3) : 0;
        end
        repeat (5) @(posedge clk);
        rst_n     <= 1'b1;
        run_checks = 1'b1;
        @(negedge clk);
        check_reset_state();

        // Allocate in program order, launch each row on its own thread
        for (int r = 0; r < NUM_ROWS; r++) begin
            alloc_row(r);
            fork
                automatic int k = r;
                launch_row(k);
            join_none
        end
        wait (n_retired == NUM_ROWS);
        @(negedge clk);
        assert (saw_full) else report_error("alloc_ready never dropped with the ROB full");
        assert (saw_backpressure) else report_error("no cycle held more than two waiting results");
        finish_run();
    end

endmodule

// ==== writeback_top.f ====
hw/uarch_pkg.sv
hw/fu_result_buffer.sv
hw/cdb_arbiter.sv
hw/rob_tracker.sv
hw/writeback_top.sv
bench/writeback_sva.sv
bench/writeback_tb.sv

// ==== Bender.yml ====
package:
  name: writeback

sources:
  - files:
      - hw/uarch_pkg.sv
      - hw/fu_result_buffer.sv
      - hw/cdb_arbiter.sv
      - hw/rob_tracker.sv
      - hw/writeback_top.sv
  - target: test
    files:
      - bench/writeback_sva.sv
      - bench/writeback_tb.sv
